//--- hw/lsu_axi_pkg.sv
`default_nettype none

package lsu_axi_pkg;

    // size codes as carried by the pipeline
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;
    localparam logic [1:0] SIZE_D = 2'd3;

    localparam logic [1:0] RESP_OKAY = 2'b00; // anything else is an error

    // unprivileged, secure, data access
    localparam logic [2:0] PROT_DATA = 3'b000;

    // controller states
    localparam int         STATE_W  = 3;
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_CHECK = 3'd1;
    localparam logic [2:0] ST_AW    = 3'd2;
    localparam logic [2:0] ST_W     = 3'd3;
    localparam logic [2:0] ST_B     = 3'd4;
    localparam logic [2:0] ST_AR    = 3'd5;
    localparam logic [2:0] ST_R     = 3'd6;
    localparam logic [2:0] ST_DONE  = 3'd7;

    typedef struct packed {
        logic        we;    // 1 = store
        logic [63:0] addr;
        logic [1:0]  size;
        logic        uns;   // zero-extend on load
        logic [63:0] wdata; // store data in low bits
    } lsu_req_t;

    typedef struct packed {
        logic [63:0] data;
        logic        err;
    } lsu_rsp_t;

    typedef struct packed {
        logic [63:0] addr; // 8-byte aligned
        logic [2:0]  size;
        logic [2:0]  prot;
    } axi_ax_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [63:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

endpackage

`default_nettype wire

//--- hw/lane_map.sv
`timescale 1ns/100ps
`default_nettype none

module lane_map (
    input  lsu_axi_pkg::lsu_req_t req_i,
    output logic [7:0]            strb_o,
    output logic [63:0]           wdata_o,
    output logic                  misaligned_o
);

    logic [2:0] offset;
    logic [7:0] mask;

    assign offset = req_i.addr[2:0];

    // byte count mask and alignment rule per size
    always_comb begin
        mask         = 8'hff;
        misaligned_o = 1'b0;
        case (req_i.size)
            lsu_axi_pkg::SIZE_B: begin
                mask         = 8'h01;
                misaligned_o = 1'b0; // bytes always fit
            end
            lsu_axi_pkg::SIZE_H: begin
                mask         = 8'h03;
                misaligned_o = offset[0];
            end
            lsu_axi_pkg::SIZE_W: begin
                mask         = 8'h0f;
                misaligned_o = |offset[1:0];
            end
            lsu_axi_pkg::SIZE_D: begin
                mask         = 8'hff;
                misaligned_o = |offset;
            end
            default: begin
                mask         = 8'hff;
                misaligned_o = 1'b1;
            end
        endcase
    end

    // move mask and data up to the addressed lanes
    always_comb begin
        strb_o  = mask << offset;
        wdata_o = req_i.wdata << {offset, 3'b000};
    end

endmodule

`default_nettype wire

//--- hw/load_extract.sv
`timescale 1ns/100ps
`default_nettype none

module load_extract (
    input  lsu_axi_pkg::lsu_req_t req_i,
    input  logic [63:0]           rdata_i,
    output logic [63:0]           ldata_o
);

    logic [63:0] shifted;
    logic        sext;

    assign shifted = rdata_i >> {req_i.addr[2:0], 3'b000}; // addressed byte to lane 0
    assign sext    = ~req_i.uns;

    always_comb begin
        case (req_i.size)
            lsu_axi_pkg::SIZE_B: begin
                ldata_o = {{56{sext & shifted[7]}}, shifted[7:0]};
            end
            lsu_axi_pkg::SIZE_H: begin
                ldata_o = {{48{sext & shifted[15]}}, shifted[15:0]};
            end
            lsu_axi_pkg::SIZE_W: begin
                ldata_o = {{32{sext & shifted[31]}}, shifted[31:0]};
            end
            lsu_axi_pkg::SIZE_D: begin
                ldata_o = shifted; // no extension needed
            end
            default: begin
                ldata_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/lsu_axi_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_axi_ctrl (
    input  logic                  clk,
    input  logic                  rst,

    // pipeline request port
    input  logic                  req_valid_i,
    input  lsu_axi_pkg::lsu_req_t req_i,
    output logic                  busy_o,
    output logic                  done_o,
    output lsu_axi_pkg::lsu_rsp_t rsp_o,

    // lane modules
    input  logic                  misaligned_i,
    input  logic [7:0]            strb_i,
    input  logic [63:0]           wdata_i,
    input  logic [63:0]           ldata_i,
    output lsu_axi_pkg::lsu_req_t req_o,

    // AXI write
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output lsu_axi_pkg::axi_ax_t  aw_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    output lsu_axi_pkg::axi_w_t   w_o,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    input  logic [1:0]            b_resp_i,

    // AXI read
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output lsu_axi_pkg::axi_ax_t  ar_o,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  lsu_axi_pkg::axi_r_t   r_i
);

    logic [lsu_axi_pkg::STATE_W-1:0] state;
    lsu_axi_pkg::lsu_req_t           req_q;
    lsu_axi_pkg::lsu_rsp_t           rsp_q;
    lsu_axi_pkg::axi_ax_t            ax;

    logic capture;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    logic fault; // misaligned, seen in check

    assign capture = (state == lsu_axi_pkg::ST_IDLE) & req_valid_i;
    assign aw_hs   = aw_valid_o & aw_ready_i;
    assign w_hs    = w_valid_o & w_ready_i;
    assign b_hs    = b_valid_i & b_ready_o;
    assign ar_hs   = ar_valid_o & ar_ready_i;
    assign r_hs    = r_valid_i & r_ready_o;
    assign fault   = (state == lsu_axi_pkg::ST_CHECK) & misaligned_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_axi_pkg::ST_IDLE;
        end else begin
            case (state)
                lsu_axi_pkg::ST_IDLE: begin
                    if (req_valid_i) state <= lsu_axi_pkg::ST_CHECK;
                end
                lsu_axi_pkg::ST_CHECK: begin
                    if (misaligned_i) begin
                        state <= lsu_axi_pkg::ST_IDLE; // done already shown
                    end else if (req_q.we) begin
                        state <= lsu_axi_pkg::ST_AW;
                    end else begin
                        state <= lsu_axi_pkg::ST_AR;
                    end
                end
                lsu_axi_pkg::ST_AW: begin
                    if (aw_hs) state <= lsu_axi_pkg::ST_W;
                end
                lsu_axi_pkg::ST_W: begin
                    if (w_hs) state <= lsu_axi_pkg::ST_B;
                end
                lsu_axi_pkg::ST_B: begin
                    if (b_hs) state <= lsu_axi_pkg::ST_DONE;
                end
                lsu_axi_pkg::ST_AR: begin
                    if (ar_hs) state <= lsu_axi_pkg::ST_R;
                end
                lsu_axi_pkg::ST_R: begin
                    if (r_hs) state <= lsu_axi_pkg::ST_DONE;
                end
                default: begin
                    state <= lsu_axi_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) req_q <= req_i;
    end

    // result of the bus response
    always_ff @(posedge clk) begin
        if (b_hs) begin
            rsp_q.data <= 64'd0;
            rsp_q.err  <= (b_resp_i != lsu_axi_pkg::RESP_OKAY);
        end else if (r_hs) begin
            rsp_q.data <= (r_i.resp == lsu_axi_pkg::RESP_OKAY) ? ldata_i : 64'd0;
            rsp_q.err  <= (r_i.resp != lsu_axi_pkg::RESP_OKAY);
        end
    end

    always_comb begin
        rsp_o = rsp_q;
        if (fault) begin
            rsp_o.data = 64'd0;
            rsp_o.err  = 1'b1;
        end
    end

    assign busy_o = (state != lsu_axi_pkg::ST_IDLE);
    assign done_o = fault | (state == lsu_axi_pkg::ST_DONE);
    assign req_o  = req_q;

    // AW and AR carry the same beat
    assign ax.addr = {req_q.addr[63:3], 3'b000};
    assign ax.size = {1'b0, req_q.size};
    assign ax.prot = lsu_axi_pkg::PROT_DATA;

    assign aw_valid_o = (state == lsu_axi_pkg::ST_AW);
    assign aw_o       = ax;
    assign w_valid_o  = (state == lsu_axi_pkg::ST_W);
    assign w_o.data   = wdata_i;
    assign w_o.strb   = strb_i;
    assign w_o.last   = 1'b1; // single beat
    assign b_ready_o  = (state == lsu_axi_pkg::ST_B);
    assign ar_valid_o = (state == lsu_axi_pkg::ST_AR);
    assign ar_o       = ax;
    assign r_ready_o  = (state == lsu_axi_pkg::ST_R);

endmodule

`default_nettype wire

//--- hw/lsu_axi_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_axi_top (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid_i,
    input  lsu_axi_pkg::lsu_req_t req_i,
    output logic                  busy_o,
    output logic                  done_o,
    output lsu_axi_pkg::lsu_rsp_t rsp_o,

    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output lsu_axi_pkg::axi_ax_t  aw_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    output lsu_axi_pkg::axi_w_t   w_o,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    input  logic [1:0]            b_resp_i,

    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output lsu_axi_pkg::axi_ax_t  ar_o,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  lsu_axi_pkg::axi_r_t   r_i
);

    lsu_axi_pkg::lsu_req_t req_q; // captured request
    logic                  misaligned;
    logic [7:0]            strb;
    logic [63:0]           wdata;
    logic [63:0]           ldata;

    lsu_axi_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .rsp_o        (rsp_o),
        .misaligned_i (misaligned),
        .strb_i       (strb),
        .wdata_i      (wdata),
        .ldata_i      (ldata),
        .req_o        (req_q),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .aw_o         (aw_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .w_o          (w_o),
        .b_valid_i    (b_valid_i),
        .b_ready_o    (b_ready_o),
        .b_resp_i     (b_resp_i),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .ar_o         (ar_o),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .r_i          (r_i)
    );

    lane_map i_lane_map (
        .req_i        (req_q),
        .strb_o       (strb),
        .wdata_o      (wdata),
        .misaligned_o (misaligned)
    );

    load_extract i_load_extract (
        .req_i   (req_q),
        .rdata_i (r_i.data),
        .ldata_o (ldata)
    );

endmodule

`default_nettype wire

//--- dv/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           offset_i, // offset of the request in flight
    output int                   strb_errors_o,

    input  logic                 aw_valid_i,
    output logic                 aw_ready_o,
    input  lsu_axi_pkg::axi_ax_t aw_i,
    input  logic                 w_valid_i,
    output logic                 w_ready_o,
    input  lsu_axi_pkg::axi_w_t  w_i,
    output logic                 b_valid_o,
    input  logic                 b_ready_i,
    output logic [1:0]           b_resp_o,

    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    input  lsu_axi_pkg::axi_ax_t ar_i,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output lsu_axi_pkg::axi_r_t  r_o
);

    typedef enum logic [1:0] {PH_ADDR, PH_W, PH_B, PH_R} phase_t;

    logic [7:0]  mem [0:4095];
    logic [15:0] lfsr = 16'd10200;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // two bits, one step each, so 0 to 3 cycles
    function automatic int draw_delay();
        int d;
        d = 0;
        repeat (2) begin
            d    = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return d;
    endfunction

    function automatic logic [7:0] size_mask(input logic [2:0] size);
        return 8'((9'd1 << (1 << size)) - 9'd1); // 2**bytes - 1
    endfunction

    initial begin : slave
        phase_t               phase;
        int                   cnt;
        int                   a;
        logic                 in_range;
        logic [7:0]           exp_strb;
        lsu_axi_pkg::axi_ax_t ax_q;
        lsu_axi_pkg::axi_r_t  beat;

        for (a = 0; a < 4096; a++) begin
            mem[a] = a[7:0] ^ a[11:4];
        end
        strb_errors_o = 0;
        aw_ready_o    = 1'b0;
        w_ready_o     = 1'b0;
        b_valid_o     = 1'b0;
        b_resp_o      = 2'b00;
        ar_ready_o    = 1'b0;
        r_valid_o     = 1'b0;
        r_o           = '0;
        phase         = PH_ADDR;
        cnt           = 0;
        in_range      = 1'b0;
        ax_q          = '0;
        forever begin
            @(posedge clk);
            if (rst) begin
                phase = PH_ADDR;
                cnt   = 0;
                aw_ready_o <= #1 1'b0;
                w_ready_o  <= #1 1'b0;
                b_valid_o  <= #1 1'b0;
                ar_ready_o <= #1 1'b0;
                r_valid_o  <= #1 1'b0;
            end else begin
                case (phase)
                    PH_ADDR: begin
                        if (aw_valid_i && aw_ready_o) begin
                            ax_q  = aw_i;
                            phase = PH_W;
                            cnt   = draw_delay();
                            aw_ready_o <= #1 1'b0;
                        end else if (ar_valid_i && ar_ready_o) begin
                            ax_q  = ar_i;
                            phase = PH_R;
                            cnt   = draw_delay();
                            ar_ready_o <= #1 1'b0;
                        end else if (aw_valid_i || ar_valid_i) begin
                            if (cnt == 0) begin
                                aw_ready_o <= #1 aw_valid_i;
                                ar_ready_o <= #1 ar_valid_i;
                            end else begin
                                cnt--;
                            end
                        end
                        in_range = (ax_q.addr < 64'h1000);
                    end
                    PH_W: begin
                        if (w_valid_i && w_ready_o) begin
                            exp_strb = size_mask(ax_q.size) << (ax_q.addr[2:0] | offset_i);
                            assert (w_i.strb == exp_strb) else begin
                                $display("FAILED w_strobe at %h: expected %h actual %h",
                                         ax_q.addr, exp_strb, w_i.strb);
                                strb_errors_o++;
                            end
                            for (a = 0; a < 8; a++) begin
                                if (in_range && w_i.strb[a]) begin
                                    mem[{ax_q.addr[11:3], a[2:0]}] = w_i.data[8*a +: 8];
                                end
                            end
                            phase = PH_B;
                            cnt   = draw_delay();
                            w_ready_o <= #1 1'b0;
                        end else if (w_valid_i) begin
                            if (cnt == 0) begin
                                w_ready_o <= #1 1'b1;
                            end else begin
                                cnt--;
                            end
                        end
                    end
                    PH_B: begin
                        if (b_valid_o && b_ready_i) begin
                            phase = PH_ADDR;
                            cnt   = draw_delay();
                            b_valid_o <= #1 1'b0;
                        end else if (!b_valid_o) begin
                            if (cnt == 0) begin
                                b_valid_o <= #1 1'b1;
                                b_resp_o  <= #1 in_range ? lsu_axi_pkg::RESP_OKAY : 2'b10;
                            end else begin
                                cnt--;
                            end
                        end
                    end
                    default: begin
                        if (r_valid_o && r_ready_i) begin
                            phase = PH_ADDR;
                            cnt   = draw_delay();
                            r_valid_o <= #1 1'b0;
                        end else if (!r_valid_o) begin
                            if (cnt == 0) begin
                                beat.data = '0;
                                beat.resp = in_range ? lsu_axi_pkg::RESP_OKAY : 2'b10; // SLVERR
                                beat.last = 1'b1;
                                for (a = 0; a < 8; a++) begin
                                    if (in_range) begin
                                        beat.data[8*a +: 8] = mem[{ax_q.addr[11:3], a[2:0]}];
                                    end
                                end
                                r_o       <= #1 beat;
                                r_valid_o <= #1 1'b1;
                            end else begin
                                cnt--;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_lsu_axi.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_axi;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    lsu_axi_pkg::lsu_req_t req;
    logic                  busy;
    logic                  done;
    lsu_axi_pkg::lsu_rsp_t rsp;
    logic                  aw_valid;
    logic                  aw_ready;
    lsu_axi_pkg::axi_ax_t  aw;
    logic                  w_valid;
    logic                  w_ready;
    lsu_axi_pkg::axi_w_t   w;
    logic                  b_valid;
    logic                  b_ready;
    logic [1:0]            b_resp;
    logic                  ar_valid;
    logic                  ar_ready;
    lsu_axi_pkg::axi_ax_t  ar;
    logic                  r_valid;
    logic                  r_ready;
    lsu_axi_pkg::axi_r_t   r;
    logic [2:0]            offset; // offset of the last captured request
    int                    strb_errors;
    int                    errors;
    int                    checks;

    lsu_axi_top i_dut (
        .clk (clk), .rst (rst),
        .req_valid_i (req_valid), .req_i (req), .busy_o (busy), .done_o (done), .rsp_o (rsp),
        .aw_valid_o (aw_valid), .aw_ready_i (aw_ready), .aw_o (aw),
        .w_valid_o (w_valid), .w_ready_i (w_ready), .w_o (w),
        .b_valid_i (b_valid), .b_ready_o (b_ready), .b_resp_i (b_resp),
        .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_o (ar),
        .r_valid_i (r_valid), .r_ready_o (r_ready), .r_i (r)
    );

    axi_mem_model i_mem (
        .clk (clk), .rst (rst), .offset_i (offset), .strb_errors_o (strb_errors),
        .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_i (aw),
        .w_valid_i (w_valid), .w_ready_o (w_ready), .w_i (w),
        .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp),
        .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_i (ar),
        .r_valid_o (r_valid), .r_ready_i (r_ready), .r_o (r)
    );

    always #5 clk = ~clk;

    // offset must be a multiple of the byte count
    function automatic logic is_misaligned(input logic [1:0] size, input logic [2:0] off);
        return (off & ((3'd1 << size) - 3'd1)) != 3'd0;
    endfunction

    task automatic check_value(input string tname, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act == exp) else begin
            $display("FAILED %0s %0s: expected %h actual %h", tname, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input string tname, input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%0s: %0s", tname, msg);
            errors++;
        end
    endtask

    // dword aligned address, request size, unprivileged secure data prot
    task automatic check_addr_beat(input string tname, input lsu_axi_pkg::lsu_req_t rq,
                                   input lsu_axi_pkg::axi_ax_t ax);
        check_value(tname, "ax_addr", rq.addr & ~64'h7, ax.addr);
        check_value(tname, "ax_size", 64'(rq.size), 64'(ax.size));
        check_value(tname, "ax_prot", 64'd0, 64'(ax.prot));
    endtask

    task automatic run_request(input string tname, input lsu_axi_pkg::lsu_req_t rq,
                               input logic [63:0] exp_data, input logic exp_err,
                               output logic timed_out);
        lsu_axi_pkg::lsu_rsp_t got;
        logic                  got_done;
        logic                  ax_seen;
        int                    cycles;
        got       = '0;
        got_done  = 1'b0;
        ax_seen   = 1'b0;
        cycles    = 0;
        timed_out = 1'b0;
        @(posedge clk);
        #1;
        check_true(tname, !busy, "DUT busy before the request");
        req       = rq;
        req_valid = 1'b1;
        offset    = rq.addr[2:0];
        @(posedge clk);
        #1;
        // dword store strobed while busy must be ignored
        req.we    = 1'b1;
        req.addr  = {rq.addr[63:3], 3'b000};
        req.size  = lsu_axi_pkg::SIZE_D;
        req.wdata = 64'hbad0_bad0_bad0_bad0;
        while (!got_done && cycles < 50) begin
            @(negedge clk);
            cycles++;
            ax_seen = ax_seen | aw_valid | ar_valid;
            if (aw_valid) begin
                check_addr_beat(tname, rq, aw);
            end
            if (ar_valid) begin
                check_addr_beat(tname, rq, ar);
            end
            if (w_valid) begin
                check_value(tname, "w_last", 64'd1, 64'(w.last));
            end
            if (done) begin
                got_done = 1'b1;
                got      = rsp;
            end
            if (cycles == 1) begin
                check_true(tname, busy, "busy_o low in the cycle after capture");
                @(posedge clk);
                #1;
                req_valid = 1'b0;
            end
        end
        if (!got_done) begin
            $display("%0s: no done from the DUT within 50 cycles", tname);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value(tname, "data", exp_data, got.data);
            check_value(tname, "err", 64'(exp_err), 64'(got.err));
            if (is_misaligned(rq.size, rq.addr[2:0])) begin
                check_true(tname, cycles == 1, "misaligned request not done after capture");
                check_true(tname, !ax_seen, "address valid raised for a misaligned request");
            end
        end
    endtask

    initial begin
        string                 line;
        string                 tname;
        lsu_axi_pkg::lsu_req_t rq;
        logic                  we;
        logic [63:0]           addr;
        logic [1:0]            size;
        logic                  uns;
        logic [63:0]           wdata;
        logic [63:0]           exp_data;
        logic                  exp_err;
        logic                  timed_out;
        int                    fd;
        int                    n;
        int                    nvec;
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        offset    = 3'd0;
        errors    = 0;
        checks    = 0;
        nvec      = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        fd  = $fopen("dv/lsu_axi_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/lsu_axi_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line  = "";
                tname = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                            tname, we, addr, size, uns, wdata, exp_data, exp_err);
                if (n == 8) begin
                    rq.we    = we;
                    rq.addr  = addr;
                    rq.size  = size;
                    rq.uns   = uns;
                    rq.wdata = wdata;
                    nvec++;
                    run_request(tname, rq, exp_data, exp_err, timed_out);
                end else if (n > 0 && tname != "#") begin
                    $display("malformed vector line: %0s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
        errors = errors + strb_errors;
        $display("vectors %0d, checks %0d, errors %0d", nvec, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/lsu_axi_pkg.sv
hw/lane_map.sv
hw/load_extract.sv
hw/lsu_axi_ctrl.sv
hw/lsu_axi_top.sv
dv/axi_mem_model.sv
dv/tb_lsu_axi.sv

//--- dv/lsu_axi_vectors.txt
# name we addr size(0=B 1=H 2=W 3=D) uns wdata exp_data exp_err, numbers in hex
# stores expect zero data; misaligned and out-of-range accesses expect err 1
sd_base      1 100  3 0 0123456789abcdef 0000000000000000 0
ld_base      0 100  3 0 0000000000000000 0123456789abcdef 0
sd_init_b    1 108  3 0 1111111111111111 0000000000000000 0
sb_off0      1 108  0 0 ffffffffffffffa0 0000000000000000 0
sb_off7      1 10f  0 0 00000000000000a7 0000000000000000 0
sh_off2      1 10a  1 0 000000000000b3b2 0000000000000000 0
sh_off4      1 10c  1 0 ffffffffffffb5b4 0000000000000000 0
ld_merge_b   0 108  3 0 0000000000000000 a711b5b4b3b211a0 0
sd_init_e    1 110  3 0 2222222222222222 0000000000000000 0
sb_off3      1 113  0 0 00000000000000c3 0000000000000000 0
sb_off5      1 115  0 0 ffffffffffffffc5 0000000000000000 0
sh_off6      1 116  1 0 0000000000008081 0000000000000000 0
ld_merge_e   0 110  3 0 0000000000000000 8081c522c3222222 0
sw_off0      1 118  2 0 ffffffff87654321 0000000000000000 0
sw_off4      1 11c  2 0 00000000f0e0d0c0 0000000000000000 0
lw_off4      0 11c  2 0 0000000000000000 fffffffff0e0d0c0 0
lwu_off0     0 118  2 1 0000000000000000 0000000087654321 0
lh_off2      0 11a  1 0 0000000000000000 ffffffffffff8765 0
lhu_off6     0 11e  1 1 0000000000000000 000000000000f0e0 0
lb_off7      0 11f  0 0 0000000000000000 fffffffffffffff0 0
lbu_off1     0 119  0 1 0000000000000000 0000000000000043 0
lb_off0      0 118  0 0 0000000000000000 0000000000000021 0
sh_mis       1 119  1 0 000000000000ffff 0000000000000000 1
lw_mis       0 11a  2 0 0000000000000000 0000000000000000 1
sd_mis       1 11c  3 0 ffffffffffffffff 0000000000000000 1
ld_after_mis 0 118  3 0 0000000000000000 f0e0d0c087654321 0
sd_oob       1 1000 3 0 5555555555555555 0000000000000000 1
ld_oob       0 2008 3 0 0000000000000000 0000000000000000 1
